// File: flist.f
hw/gfx_pkg.sv
hw/draw_line.sv
hw/shape_drawer.sv
hw/framebuffer.sv
hw/gfx_top.sv
verification/tb_gfx_top.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the drawing engine testbench, exit status is the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -j 0 --top-module tb_gfx_top \
    -f flist.f -o sim_tb_gfx_top \
    && ./obj_dir/sim_tb_gfx_top \
    || exit 1

// File: verification/tb_gfx_top.sv
// ########################################
// testbench for the drawing engine, lcg
// stimulus, bresenham and framebuffer models
// ########################################

module tb_gfx_top
    import gfx_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned seed = 30;
    localparam int n_directed   = 13;           // fixed shapes before the random ones
    localparam int n_random     = 60;
    localparam int n_reads      = 12;           // readbacks after each shape
    localparam int max_span     = 300;          // vertices stay below this
    localparam int stall_factor = 4;            // oe low at most half the time on average
    localparam int cycle_limit  = (n_directed + n_random)
                                * (3 * (max_span + 8) * stall_factor + 2 * n_reads + 8)
                                + 1000;

    logic   clk, rst, start, is_tri, oe;
    coord_t x0, y0, x1, y1, x2, y2, rd_x, rd_y;
    color_t color;
    coord_t pix_x, pix_y;
    color_t pix_color, rd_color;
    logic   pix_valid, busy, done;

    logic [31:0] lcg_state;
    int          cycle_cnt;
    int          oe_mode;                       // 0 always on, 1 half, 2 three quarters
    int          exp_count;                     // sum of larger span + 1 per edge
    int          exp_x[$], exp_y[$];            // pixels still to come
    int          drawn_x[$], drawn_y[$];        // pixels of the last shape
    color_t      shadow [fb_depth];             // expected framebuffer
    bit          written [fb_depth];

    gfx_top gfx_top_i (
        .clk(clk), .rst(rst), .start(start), .is_tri(is_tri), .oe(oe),
        .x0(x0), .y0(y0), .x1(x1), .y1(y1), .x2(x2), .y2(y2),
        .rd_x(rd_x), .rd_y(rd_y), .color(color),
        .pix_x(pix_x), .pix_y(pix_y), .pix_color(pix_color), .rd_color(rd_color),
        .pix_valid(pix_valid), .busy(busy), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                 // 100 ns period
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {16'd0, lcg_state[30:15]};       // upper bits as the low ones cycle fast
    endfunction

    function automatic int rand_below(input int n);
        return int'(lcg_next() % 32'(n));
    endfunction

    // mostly on screen with one in eight anywhere below max_span
    function automatic int rand_coord(input int lim);
        if (rand_below(8) == 0) begin
            return rand_below(max_span);
        end
        return rand_below(lim);
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "run stopped at %0d ns", $time);
    endtask

    task automatic compare_coord(input string name, input coord_t expected, input coord_t actual);
        if (actual !== expected) begin
            $display("** Error at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
            abort_run("coordinate mismatch");
        end
    endtask

    task automatic compare_color(input string name, input color_t expected, input color_t actual);
        if (actual !== expected) begin
            $display("** Error at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
            abort_run("colour mismatch");
        end
    endtask

    task automatic compare_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
            abort_run("control signal mismatch");
        end
    endtask

    // inputs change 10 ns past the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #10;
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            abort_run("timeout: the engine stopped making progress");
        end
        case (oe_mode)
            1:       oe = (rand_below(2) == 0);
            2:       oe = (rand_below(4) != 0);
            default: oe = 1'b1;
        endcase
    endtask

    // reference bresenham appending the pixels of one edge
    task automatic model_edge(input int ax, input int ay, input int bx, input int by);
        int dx, dy, sx, sy, err, e2, px, py;
        dx  = (bx > ax) ? bx - ax : ax - bx;
        dy  = (by > ay) ? ay - by : by - ay;   // negative span
        sx  = (ax < bx) ? 1 : -1;
        sy  = (ay < by) ? 1 : -1;
        err = dx + dy;
        px  = ax;
        py  = ay;
        exp_count += ((dx > -dy) ? dx : -dy) + 1;
        while (1) begin
            exp_x.push_back(px);
            exp_y.push_back(py);
            if (px == bx && py == by) begin
                break;
            end
            e2 = 2 * err;
            if (e2 >= dy) begin
                err += dy;
                px  += sx;
            end
            if (e2 <= dx) begin
                err += dx;
                py  += sy;
            end
        end
    endtask

    // garbage on the command inputs so only the latched copy can draw
    task automatic scramble_command();
        x0     = coord_t'(rand_below(1024));
        y0     = coord_t'(rand_below(1024));
        x1     = coord_t'(rand_below(1024));
        y1     = coord_t'(rand_below(1024));
        x2     = coord_t'(rand_below(1024));
        y2     = coord_t'(rand_below(1024));
        is_tri = rand_below(2) == 0;
        color  = color_t'(rand_below(16));
    endtask

    task automatic run_command(input logic tri_cmd, input int ax, input int ay, input int bx,
                               input int by, input int cx, input int cy, input color_t c);
        int   seen, tail, px, py, addr;
        logic finished;
        exp_x.delete();
        exp_y.delete();
        exp_count = 0;
        model_edge(ax, ay, bx, by);
        if (tri_cmd) begin
            model_edge(bx, by, cx, cy);
            model_edge(cx, cy, ax, ay);
        end
        drawn_x = exp_x;
        drawn_y = exp_y;
        next_cycle();
        compare_bit("busy", 1'b0, busy);
        start  = 1'b1;
        is_tri = tri_cmd;
        x0 = coord_t'(ax);
        y0 = coord_t'(ay);
        x1 = coord_t'(bx);
        y1 = coord_t'(by);
        x2 = coord_t'(cx);
        y2 = coord_t'(cy);
        color    = c;
        seen     = 0;
        tail     = 0;
        finished = 1'b0;
        while (!finished) begin
            next_cycle();
            start = 1'b0;
            scramble_command();
            if (busy && rand_below(16) == 0) begin
                start = 1'b1;               // must be ignored
            end
            #40;                            // outputs settled by the falling edge
            if (!oe) begin
                compare_bit("pix_valid", 1'b0, pix_valid);
            end
            if (pix_valid) begin
                if (exp_x.size() == 0) begin
                    abort_run("extra pixel after the last modelled pixel");
                end
                px = exp_x.pop_front();
                py = exp_y.pop_front();
                compare_coord("pix_x", coord_t'(px), pix_x);
                compare_coord("pix_y", coord_t'(py), pix_y);
                compare_color("pix_color", c, pix_color);
                if (px < scr_w && py < scr_h) begin
                    addr          = py * scr_w + px;
                    shadow[addr]  = c;
                    written[addr] = 1'b1;
                end
                seen++;
            end
            if (done) begin
                finished = 1'b1;
                compare_bit("busy", 1'b0, busy);
                if (exp_x.size() != 0) begin
                    abort_run("done pulsed before the last modelled pixel");
                end
                if (seen != exp_count) begin
                    abort_run("pixel count differs from the larger span plus one");
                end
            end else begin
                compare_bit("busy", 1'b1, busy);    // held from the cycle after start
                if (exp_x.size() == 0) begin
                    tail++;
                    if (tail > 2) begin
                        abort_run("done missing after the final pixel");
                    end
                end
            end
        end
        start = 1'b0;
    endtask

    // half the reads from drawn pixels and half anywhere
    task automatic readback();
        int k, idx, px, py, addr;
        for (k = 0; k < n_reads; k++) begin
            if (k % 2 == 0 && drawn_x.size() > 0) begin
                idx = rand_below(drawn_x.size());
                px  = drawn_x[idx];
                py  = drawn_y[idx];
            end else begin
                px = rand_below(max_span);
                py = rand_below(max_span);
            end
            next_cycle();
            rd_x = coord_t'(px);
            rd_y = coord_t'(py);
            #40;
            compare_bit("done", 1'b0, done);        // one pulse per shape only
            compare_bit("busy", 1'b0, busy);
            compare_bit("pix_valid", 1'b0, pix_valid);
            next_cycle();
            #40;
            if (px < scr_w && py < scr_h) begin
                addr = py * scr_w + px;
                if (written[addr]) begin            // unwritten cells hold no known value
                    compare_color("rd_color", shadow[addr], rd_color);
                end
            end else begin
                compare_color("rd_color", color_t'(0), rd_color);
            end
        end
    endtask

    task automatic shape(input logic tri_cmd, input int ax, input int ay, input int bx,
                         input int by, input int cx, input int cy, input color_t c);
        run_command(tri_cmd, ax, ay, bx, by, cx, cy, c);
        readback();
    endtask

    initial begin
        int i, t;
        lcg_state = seed;
        cycle_cnt = 0;
        oe_mode   = 0;
        exp_count = 0;
        rst    = 1'b1;
        start  = 1'b0;
        is_tri = 1'b0;
        oe     = 1'b0;
        x0 = '0;
        y0 = '0;
        x1 = '0;
        y1 = '0;
        x2 = '0;
        y2 = '0;
        rd_x  = '0;
        rd_y  = '0;
        color = '0;
        repeat (8) @(posedge clk);
        #10;
        rst = 1'b0;
        #40;
        compare_bit("busy", 1'b0, busy);
        compare_bit("done", 1'b0, done);
        compare_bit("pix_valid", 1'b0, pix_valid);

        shape(1'b0, 10, 10, 60, 10, 0, 0, 4'd1);         // horizontal in both directions
        shape(1'b0, 60, 20, 10, 20, 0, 0, 4'd2);
        shape(1'b0, 30, 5, 30, 80, 0, 0, 4'd3);          // vertical in both directions
        shape(1'b0, 35, 80, 35, 5, 0, 0, 4'd4);
        shape(1'b0, 0, 0, 50, 50, 0, 0, 4'd5);           // diagonals
        shape(1'b0, 100, 100, 50, 50, 0, 0, 4'd6);
        shape(1'b0, 20, 90, 70, 40, 0, 0, 4'd7);
        shape(1'b0, 5, 5, 15, 100, 0, 0, 4'd8);          // steep
        shape(1'b0, 15, 100, 5, 5, 0, 0, 4'd9);
        shape(1'b0, 80, 60, 80, 60, 0, 0, 4'd10);        // single point
        shape(1'b0, 150, 110, 200, 140, 0, 0, 4'd11);    // leaves the screen
        shape(1'b1, 20, 20, 120, 40, 60, 110, 4'd12);
        shape(1'b1, 90, 90, 90, 90, 90, 90, 4'd13);      // degenerate triangle

        for (i = 0; i < n_random; i++) begin
            oe_mode = rand_below(3);
            t = rand_below(2);
            shape(t == 1, rand_coord(scr_w), rand_coord(scr_h), rand_coord(scr_w),
                  rand_coord(scr_h), rand_coord(scr_w), rand_coord(scr_h),
                  color_t'(rand_below(16)));
        end

        $display("TEST OK");
        $finish;
    end

endmodule

// File: hw/gfx_top.sv
// ########################################
// drawing engine top, shape sequencer,
// line drawer and framebuffer
// ########################################

module gfx_top
    import gfx_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   start,       // shape command strobe
    input  logic   is_tri,      // triangle when high
    input  logic   oe,          // pixel advance enable
    input  coord_t x0,
    input  coord_t y0,
    input  coord_t x1,
    input  coord_t y1,
    input  coord_t x2,
    input  coord_t y2,
    input  coord_t rd_x,        // framebuffer read address
    input  coord_t rd_y,
    input  color_t color,
    output coord_t pix_x,       // pixel stream
    output coord_t pix_y,
    output color_t pix_color,
    output color_t rd_color,
    output logic   pix_valid,
    output logic   busy,
    output logic   done
);

    logic   line_start;         // sequencer -> line drawer
    logic   line_done;          // line drawer -> sequencer
    coord_t lx0, ly0;           // current edge
    coord_t lx1, ly1;

    shape_drawer shape_drawer_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .is_tri     (is_tri),
        .line_done  (line_done),
        .x0         (x0),
        .y0         (y0),
        .x1         (x1),
        .y1         (y1),
        .x2         (x2),
        .y2         (y2),
        .color      (color),
        .line_start (line_start),
        .busy       (busy),
        .done       (done),
        .lx0        (lx0),
        .ly0        (ly0),
        .lx1        (lx1),
        .ly1        (ly1),
        .pix_color  (pix_color)
    );

    draw_line draw_line_i (
        .clk     (clk),
        .rst     (rst),
        .start   (line_start),
        .oe      (oe),
        .x0      (lx0),
        .y0      (ly0),
        .x1      (lx1),
        .y1      (ly1),
        .x       (pix_x),
        .y       (pix_y),
        .drawing (pix_valid),   // one pixel per high cycle
        .done    (line_done)
    );

    framebuffer framebuffer_i (
        .clk      (clk),
        .we       (pix_valid),  // every emitted pixel is stored
        .wx       (pix_x),
        .wy       (pix_y),
        .wcolor   (pix_color),
        .rd_x     (rd_x),
        .rd_y     (rd_y),
        .rd_color (rd_color)
    );

endmodule

// File: hw/framebuffer.sv
// ########################################
// pixel store, clipped write port and
// registered read port
// ########################################

module framebuffer
    import gfx_pkg::*;
(
    input  logic   clk,
    input  logic   we,          // pixel write strobe
    input  coord_t wx,
    input  coord_t wy,
    input  color_t wcolor,
    input  coord_t rd_x,
    input  coord_t rd_y,
    output color_t rd_color     // valid the cycle after rd_x/rd_y
);

    color_t   mem [fb_depth];   // one palette index per pixel

    fb_addr_t wr_addr;
    fb_addr_t rd_addr;
    logic     wr_on;            // write target on screen
    logic     rd_on;

    // row-major linear address
    function automatic fb_addr_t pix_addr(input coord_t px, input coord_t py);
        return fb_addr_t'(py * scr_w + px);
    endfunction

    assign wr_on   = (wx < scr_w) && (wy < scr_h);
    assign rd_on   = (rd_x < scr_w) && (rd_y < scr_h);
    assign wr_addr = pix_addr(wx, wy);
    assign rd_addr = pix_addr(rd_x, rd_y);

    always_ff @(posedge clk) begin
        if (we && wr_on) begin  // off-screen pixels dropped
            mem[wr_addr] <= wcolor;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_on) begin
            rd_color <= mem[rd_addr];
        end else begin
            rd_color <= '0;     // outside the screen reads as zero
        end
    end

endmodule

// File: hw/shape_drawer.sv
// ########################################
// shape sequencer, runs the line drawer
// once per edge of a line or triangle
// ########################################

module shape_drawer
    import gfx_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   start,       // command strobe, ignored while busy
    input  logic   is_tri,      // 1: triangle v0-v1-v2, 0: line v0-v1
    input  logic   line_done,   // edge finished
    input  coord_t x0,
    input  coord_t y0,
    input  coord_t x1,
    input  coord_t y1,
    input  coord_t x2,
    input  coord_t y2,
    input  color_t color,
    output logic   line_start,  // one pulse per edge
    output logic   busy,
    output logic   done,        // one pulse per shape
    output coord_t lx0,         // edge start
    output coord_t ly0,
    output coord_t lx1,         // edge end
    output coord_t ly1,
    output color_t pix_color
);

    shape_state_t state;

    coord_t     vx [3];         // latched vertices
    coord_t     vy [3];
    color_t     color_q;
    logic [1:0] edge_idx;       // edge in progress
    logic [1:0] last_edge;      // 0 for a line, 2 for a triangle
    logic       accept;
    logic       last;

    coord_t     ax, ay;         // selected edge endpoints
    coord_t     bx, by;

    assign busy      = (state == SH_LINE) || (state == SH_WAIT);
    assign done      = (state == SH_DONE);
    assign accept    = start && !busy;
    assign last      = (edge_idx == last_edge);
    assign pix_color = color_q;

    // vertex pair for the current edge
    always_comb begin
        case (edge_idx)
            2'd1: begin             // v1 -> v2
                ax = vx[1];
                ay = vy[1];
                bx = vx[2];
                by = vy[2];
            end
            2'd2: begin             // v2 -> v0, closes the triangle
                ax = vx[2];
                ay = vy[2];
                bx = vx[0];
                by = vy[0];
            end
            default: begin          // v0 -> v1
                ax = vx[0];
                ay = vy[0];
                bx = vx[1];
                by = vy[1];
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= SH_IDLE;
            line_start <= 1'b0;
            edge_idx   <= 2'd0;
        end else begin
            line_start <= 1'b0;
            case (state)
                SH_IDLE, SH_DONE: begin
                    if (accept) begin
                        edge_idx <= 2'd0;
                        state    <= SH_LINE;
                    end else begin
                        state <= SH_IDLE;
                    end
                end
                SH_LINE: begin
                    line_start <= 1'b1;     // endpoints registered alongside
                    state      <= SH_WAIT;
                end
                SH_WAIT: begin
                    if (line_done) begin
                        if (last) begin
                            state <= SH_DONE;
                        end else begin
                            edge_idx <= edge_idx + 2'd1;
                            state    <= SH_LINE;   // next start two cycles on
                        end
                    end
                end
                default: state <= SH_IDLE;
            endcase
        end
    end

    // command and edge payload
    always_ff @(posedge clk) begin
        if (accept) begin
            vx[0]     <= x0;
            vy[0]     <= y0;
            vx[1]     <= x1;
            vy[1]     <= y1;
            vx[2]     <= x2;
            vy[2]     <= y2;
            color_q   <= color;
            last_edge <= is_tri ? 2'd2 : 2'd0;
        end
        if (state == SH_LINE) begin
            lx0 <= ax;
            ly0 <= ay;
            lx1 <= bx;
            ly1 <= by;
        end
    end

endmodule

// File: hw/draw_line.sv
// ########################################
// bresenham line drawer, steps one pixel
// per cycle while oe is high
// ########################################

module draw_line
    import gfx_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   start,       // begin a line, taken in IDLE only
    input  logic   oe,          // consumer allows a pixel this cycle
    input  coord_t x0,          // start point
    input  coord_t y0,
    input  coord_t x1,          // end point
    input  coord_t y1,
    output coord_t x,           // current pixel
    output coord_t y,
    output logic   drawing,     // x/y valid this cycle
    output logic   done         // one cycle after the end pixel
);

    line_state_t state;

    // spans, registered at start
    coord_t                  adx_c, ady_c;  // absolute spans from the inputs
    logic                    right_c, down_c;
    logic signed [coord_w:0] dx_c, dy_c;
    logic signed [coord_w:0] dx;            // +|x span|
    logic signed [coord_w:0] dy;            // -|y span|
    logic                    right, down;   // step directions
    coord_t                  xe, ye;        // latched end point

    // error term
    logic signed [coord_w:0]   err;
    logic signed [coord_w:0]   derr;        // correction for this step
    logic signed [coord_w+1:0] err2;        // doubled error, one more bit
    logic                      movx, movy;
    logic                      at_end;

    always_comb begin
        right_c = (x0 < x1);
        down_c  = (y0 < y1);
        adx_c   = right_c ? x1 - x0 : x0 - x1;
        ady_c   = down_c ? y1 - y0 : y0 - y1;
        dx_c    = $signed({1'b0, adx_c});
        dy_c    = -$signed({1'b0, ady_c});  // kept negative
    end

    always_comb begin
        err2 = {err, 1'b0};
        movx = (err2 >= dy);                // x step due
        movy = (err2 <= dx);                // y step due
        derr = '0;
        if (movx) begin
            derr = derr + dy;
        end
        if (movy) begin
            derr = derr + dx;
        end
    end

    assign at_end  = (x == xe) && (y == ye);
    assign drawing = (state == DRAW) && oe;   // no pixel while stalled

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        dx    <= dx_c;
                        dy    <= dy_c;
                        right <= right_c;
                        down  <= down_c;
                        xe    <= x1;
                        ye    <= y1;
                        x     <= x0;        // first pixel is the start point
                        y     <= y0;
                        state <= INIT;
                    end
                end
                INIT: begin
                    err   <= dx + dy;
                    state <= DRAW;
                end
                DRAW: begin
                    if (oe) begin           // hold everything while stalled
                        if (at_end) begin
                            done  <= 1'b1;
                            state <= IDLE;
                        end else begin
                            if (movx) begin
                                x <= right ? x + 1'b1 : x - 1'b1;
                            end
                            if (movy) begin
                                y <= down ? y + 1'b1 : y - 1'b1;
                            end
                            err <= err + derr;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: hw/gfx_pkg.sv
// ########################################
// screen geometry, pixel types and the
// state encodings of the drawing engine
// ########################################

package gfx_pkg;

    localparam int coord_w  = 10;                  // room for off-screen vertices
    localparam int scr_w    = 160;                 // visible columns
    localparam int scr_h    = 120;                 // visible rows
    localparam int color_w  = 4;                   // palette index bits
    localparam int fb_depth = scr_w * scr_h;       // one entry per pixel

    typedef logic [coord_w-1:0]          coord_t;  // unsigned screen coordinate
    typedef logic [color_w-1:0]          color_t;  // palette index
    typedef logic [$clog2(fb_depth)-1:0] fb_addr_t; // row-major pixel address

    // line drawer
    typedef enum logic [1:0] {
        IDLE,                                      // waiting for start
        INIT,                                      // load error term
        DRAW                                       // stepping along the line
    } line_state_t;

    // shape sequencer
    typedef enum logic [1:0] {
        SH_IDLE,                                   // no command
        SH_LINE,                                   // set up next edge
        SH_WAIT,                                   // edge being drawn
        SH_DONE                                    // shape finished, done pulse
    } shape_state_t;

endpackage
